/* design/axil_pkg.sv */
// AXI-Lite bus widths, response codes and write and read channel structs
package axil_pkg;

	// Bus widths
	typedef logic [31:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0]  axil_strb_t;
	typedef logic [1:0]  axil_resp_t;

	// Response codes
	localparam axil_resp_t RESP_OKAY   = 2'd0;
	localparam axil_resp_t RESP_SLVERR = 2'd2;
	localparam axil_resp_t RESP_DECERR = 2'd3;

	// Write data channel payload
	typedef struct packed {
		axil_data_t data;
		axil_strb_t strb;
	} axil_w_t;

	// Read data channel payload
	typedef struct packed {
		axil_data_t data;
		axil_resp_t resp;
	} axil_r_t;

endpackage

/* design/soc_map_pkg.sv */
// Memory map, peripheral request and response structs, game-pad types and timing
package soc_map_pkg;

	import axil_pkg::*;

	// Boot memory, 1 KiB of words
	localparam axil_addr_t MEM_BASE          = 32'h0201_0000;
	localparam int unsigned MEM_WORDS        = 256;
	localparam int unsigned MEM_SPAN_BITS    = $clog2(MEM_WORDS) + 2;

	// System counter
	localparam axil_addr_t COUNTER_BASE      = 32'h0200_0300;
	localparam int unsigned COUNTER_SPAN_BITS = 8;

	// Game-pad reader, a single word
	localparam axil_addr_t PAD_BASE          = 32'h0200_0200;
	localparam int unsigned PAD_SPAN_BITS    = 2;

	// Pad serial timing
	localparam int unsigned PAD_TICK_CYCLES  = 256;
	localparam int unsigned PAD_BITS         = 8;

	typedef logic [7:0] word_index_t;
	typedef logic [PAD_BITS-1:0] pad_buttons_t;
	typedef logic [$clog2(PAD_TICK_CYCLES)-1:0] pad_tick_t;
	typedef logic [$clog2(PAD_BITS)-1:0] pad_bit_t;

	// Decoder to peripheral, valid for a single cycle
	typedef struct packed {
		logic        valid;
		logic        write;
		word_index_t index;
		axil_data_t  data;
		axil_strb_t  strb;
	} periph_req_t;

	// Peripheral to decoder, ack one cycle after the request
	typedef struct packed {
		logic       ack;
		logic       err;
		axil_data_t data;
	} periph_rsp_t;

endpackage

/* design/axil_decoder.sv */
// AXI-Lite slave front end, address decoder and response return path
module axil_decoder
	import axil_pkg::*;
	import soc_map_pkg::*;
(
	input  logic        clk_50mhz,
	input  logic        resetn,

	input  logic        awvalid,
	output logic        awready,
	input  axil_addr_t  aw_addr,
	input  logic        wvalid,
	output logic        wready,
	input  axil_w_t     w,
	output logic        bvalid,
	input  logic        bready,
	output axil_resp_t  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  axil_addr_t  ar_addr,
	output logic        rvalid,
	input  logic        rready,
	output axil_r_t     r,

	output periph_req_t mem_req,
	output periph_req_t cnt_req,
	output periph_req_t pad_req,
	input  periph_rsp_t mem_rsp,
	input  periph_rsp_t cnt_rsp,
	input  periph_rsp_t pad_rsp
);

	typedef enum logic [1:0] {ST_IDLE, ST_REQUEST, ST_WAIT, ST_RESPOND} state_e;
	typedef enum logic [1:0] {TGT_NONE, TGT_MEM, TGT_CNT, TGT_PAD} target_e;

	state_e      state;
	target_e     acc_target;
	target_e     target_q;
	word_index_t acc_index;
	word_index_t index_q;
	axil_addr_t  acc_addr;
	logic        wr_accept;
	logic        rd_accept;
	logic        write_q;
	axil_w_t     w_q;
	axil_resp_t  resp_q;
	axil_data_t  rdata_q;
	logic        mem_valid;
	logic        cnt_valid;
	logic        pad_valid;
	periph_rsp_t sel_rsp;

	function automatic logic in_region(input axil_addr_t addr, input axil_addr_t base,
			input int unsigned span_bits);
		return (addr >> span_bits) == (base >> span_bits);
	endfunction

	// Word offset inside the region
	function automatic word_index_t word_of(input axil_addr_t addr,
			input int unsigned span_bits);
		axil_addr_t offset;
		offset = addr & ((32'd1 << span_bits) - 32'd1);
		return word_index_t'(offset >> 2);
	endfunction

	// Writes win over reads, nothing taken while busy
	assign wr_accept = (state == ST_IDLE) && awvalid && wvalid;
	assign rd_accept = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);
	assign awready   = wr_accept;
	assign wready    = wr_accept;
	assign arready   = rd_accept;
	assign acc_addr  = wr_accept ? aw_addr : ar_addr;

	always_comb begin
		acc_target = TGT_NONE;
		acc_index  = '0;
		if (in_region(acc_addr, MEM_BASE, MEM_SPAN_BITS)) begin
			acc_target = TGT_MEM;
			acc_index  = word_of(acc_addr, MEM_SPAN_BITS);
		end else if (in_region(acc_addr, COUNTER_BASE, COUNTER_SPAN_BITS)) begin
			acc_target = TGT_CNT;
			acc_index  = word_of(acc_addr, COUNTER_SPAN_BITS);
		end else if (in_region(acc_addr, PAD_BASE, PAD_SPAN_BITS)) begin
			acc_target = TGT_PAD;
			acc_index  = word_of(acc_addr, PAD_SPAN_BITS);
		end
	end

	always_comb begin
		case (target_q)
			TGT_MEM: sel_rsp = mem_rsp;
			TGT_CNT: sel_rsp = cnt_rsp;
			TGT_PAD: sel_rsp = pad_rsp;
			default: sel_rsp = '0;
		endcase
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state     <= ST_IDLE;
			mem_valid <= 1'b0;
			cnt_valid <= 1'b0;
			pad_valid <= 1'b0;
		end else begin
			mem_valid <= 1'b0;
			cnt_valid <= 1'b0;
			pad_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wr_accept || rd_accept) begin
						state <= ST_REQUEST;
					end
				end
				ST_REQUEST: begin
					mem_valid <= (target_q == TGT_MEM);
					cnt_valid <= (target_q == TGT_CNT);
					pad_valid <= (target_q == TGT_PAD);
					state     <= ST_WAIT;
				end
				ST_WAIT: begin
					// Unmapped answers here, a step ahead of any ack
					if (target_q == TGT_NONE || sel_rsp.ack) begin
						state <= ST_RESPOND;
					end
				end
				default: begin
					if ((bvalid && bready) || (rvalid && rready)) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (wr_accept || rd_accept) begin
			target_q <= acc_target;
			index_q  <= acc_index;
			write_q  <= wr_accept;
			w_q      <= w;
		end
		if (state == ST_WAIT) begin
			if (target_q == TGT_NONE) begin
				resp_q  <= RESP_DECERR;
				rdata_q <= '0;
			end else if (sel_rsp.ack) begin
				resp_q  <= sel_rsp.err ? RESP_SLVERR : RESP_OKAY;
				rdata_q <= sel_rsp.data;
			end
		end
	end

	assign mem_req = '{valid: mem_valid, write: write_q, index: index_q,
		data: w_q.data, strb: w_q.strb};
	assign cnt_req = '{valid: cnt_valid, write: write_q, index: index_q,
		data: w_q.data, strb: w_q.strb};
	assign pad_req = '{valid: pad_valid, write: write_q, index: index_q,
		data: w_q.data, strb: w_q.strb};

	assign bvalid = (state == ST_RESPOND) && write_q;
	assign rvalid = (state == ST_RESPOND) && !write_q;
	assign bresp  = resp_q;
	assign r      = '{data: rdata_q, resp: resp_q};

	// A stalled response stays put until taken
	a_rsp_held: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		((bvalid && !bready) || (rvalid && !rready)) |=> $stable({bvalid, rvalid, bresp, r}));

	// Every peripheral answers on the next cycle
	a_ack_next: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		(mem_req.valid || cnt_req.valid || pad_req.valid) |=> sel_rsp.ack);

endmodule

/* design/scratch_memory.sv */
// Boot memory of word storage with byte-strobe writes and single-cycle reads
module scratch_memory
	import axil_pkg::*;
	import soc_map_pkg::*;
(
	input  logic        clk_50mhz,
	input  periph_req_t req,
	output periph_rsp_t rsp
);

	localparam int unsigned BYTES = $bits(axil_strb_t);

	axil_data_t mem [MEM_WORDS];

	// Strobed bytes only
	always_ff @(posedge clk_50mhz) begin
		if (req.valid && req.write) begin
			for (int b = 0; b < BYTES; b++) begin
				if (req.strb[b]) begin
					mem[req.index][8*b +: 8] <= req.data[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_50mhz) begin
		rsp.ack  <= req.valid;
		rsp.err  <= 1'b0;
		rsp.data <= mem[req.index];
	end

endmodule

/* design/cycle_counter.sv */
// Free-running system cycle counter, read-only on the bus
module cycle_counter
	import axil_pkg::*;
	import soc_map_pkg::*;
(
	input  logic        clk_50mhz,
	input  logic        resetn,
	input  periph_req_t req,
	output periph_rsp_t rsp
);

	axil_data_t count;
	logic       ack_q;
	logic       err_q;
	axil_data_t data_q;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count <= '0;
			ack_q <= 1'b0;
		end else begin
			count <= count + 1'b1;
			ack_q <= req.valid;
		end
	end

	// Writes get an error, the count is left alone
	always_ff @(posedge clk_50mhz) begin
		err_q  <= req.write;
		data_q <= count;
	end

	assign rsp = '{ack: ack_q, err: err_q, data: data_q};

endmodule

/* design/pad_reader.sv */
// Serial game-pad poller with step divider, frame FSM and button result register
module pad_reader
	import axil_pkg::*;
	import soc_map_pkg::*;
(
	input  logic        clk_50mhz,
	input  logic        resetn,
	input  periph_req_t req,
	output periph_rsp_t rsp,
	input  logic        pad0_data,
	input  logic        pad1_data,
	output logic        pad_latch,
	output logic        pad_clock
);

	typedef enum logic [1:0] {PAD_LATCH, PAD_CLK_LOW, PAD_CLK_HIGH, PAD_IDLE} pad_state_e;

	pad_state_e   state;
	pad_tick_t    tick_cnt;
	logic         tick;
	pad_bit_t     bit_cnt;
	logic         frame_done;
	logic [1:0]   pad_meta;
	logic [1:0]   pad_sync;
	pad_buttons_t shift0;
	pad_buttons_t shift1;
	pad_buttons_t pad0_q;
	pad_buttons_t pad1_q;
	logic         ack_q;
	logic         err_q;
	axil_data_t   data_q;

	assign tick = (tick_cnt == pad_tick_t'(PAD_TICK_CYCLES - 1));

	always_ff @(posedge clk_50mhz) begin
		pad_meta <= {pad1_data, pad0_data};
		pad_sync <= pad_meta;
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			tick_cnt   <= '0;
			state      <= PAD_IDLE;
			bit_cnt    <= '0;
			frame_done <= 1'b0;
			pad0_q     <= '0;
			pad1_q     <= '0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (tick) begin
				case (state)
					PAD_LATCH: begin
						bit_cnt <= '0;
						state   <= PAD_CLK_LOW;
					end
					PAD_CLK_LOW: state <= PAD_CLK_HIGH;
					PAD_CLK_HIGH: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == pad_bit_t'(PAD_BITS - 1)) begin
							frame_done <= 1'b1;
							state      <= PAD_IDLE;
						end else begin
							state <= PAD_CLK_LOW;
						end
					end
					default: begin
						// Publish only after a full frame
						if (frame_done) begin
							pad0_q <= shift0;
							pad1_q <= shift1;
						end
						frame_done <= 1'b0;
						state      <= PAD_LATCH;
					end
				endcase
			end
		end
	end

	// Pad lines idle high, a pressed button reads low
	always_ff @(posedge clk_50mhz) begin
		if (tick && state == PAD_CLK_LOW) begin
			shift0 <= {~pad_sync[0], shift0[PAD_BITS-1:1]};
			shift1 <= {~pad_sync[1], shift1[PAD_BITS-1:1]};
		end
	end

	assign pad_latch = (state == PAD_LATCH);
	assign pad_clock = (state == PAD_CLK_HIGH);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req.valid;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		err_q  <= req.write;
		data_q <= axil_data_t'({pad1_q, pad0_q});
	end

	assign rsp = '{ack: ack_q, err: err_q, data: data_q};

	// Pad lines settled when a bit is taken
	a_sample_settled: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		(tick && state == PAD_CLK_LOW) |-> $stable(pad_sync));

endmodule

/* design/periph_top.sv */
// Peripheral subsystem top level with decoder, boot memory, counter and pad reader
module periph_top
	import axil_pkg::*;
	import soc_map_pkg::*;
(
	input  logic       clk_50mhz,
	input  logic       resetn,

	input  logic       awvalid,
	output logic       awready,
	input  axil_addr_t aw_addr,
	input  logic       wvalid,
	output logic       wready,
	input  axil_w_t    w,
	output logic       bvalid,
	input  logic       bready,
	output axil_resp_t bresp,
	input  logic       arvalid,
	output logic       arready,
	input  axil_addr_t ar_addr,
	output logic       rvalid,
	input  logic       rready,
	output axil_r_t    r,

	input  logic       pad0_data,
	input  logic       pad1_data,
	output logic       pad_latch,
	output logic       pad_clock
);

	periph_req_t mem_req;
	periph_req_t cnt_req;
	periph_req_t pad_req;
	periph_rsp_t mem_rsp;
	periph_rsp_t cnt_rsp;
	periph_rsp_t pad_rsp;

	axil_decoder i_decoder (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.awvalid(awvalid),
		.awready(awready),
		.aw_addr(aw_addr),
		.wvalid(wvalid),
		.wready(wready),
		.w(w),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.ar_addr(ar_addr),
		.rvalid(rvalid),
		.rready(rready),
		.r(r),
		.mem_req(mem_req),
		.cnt_req(cnt_req),
		.pad_req(pad_req),
		.mem_rsp(mem_rsp),
		.cnt_rsp(cnt_rsp),
		.pad_rsp(pad_rsp)
	);

	scratch_memory i_boot_mem (
		.clk_50mhz(clk_50mhz),
		.req(mem_req),
		.rsp(mem_rsp)
	);

	cycle_counter i_sys_counter (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(cnt_req),
		.rsp(cnt_rsp)
	);

	pad_reader i_pad_reader (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.req(pad_req),
		.rsp(pad_rsp),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data),
		.pad_latch(pad_latch),
		.pad_clock(pad_clock)
	);

endmodule

/* testbench/tb_pad_model.sv */
// Behavioural model of one serial game-pad shift register
module tb_pad_model
	import soc_map_pkg::*;
(
	input  logic         pad_latch,
	input  logic         pad_clock,
	input  pad_buttons_t buttons,
	output logic         data
);

	timeunit 1ns;
	timeprecision 1ps;

	pad_buttons_t shreg = '0;

	// Load on latch, next button on each rising clock
	always @(posedge pad_latch or posedge pad_clock) begin
		if (pad_latch) begin
			shreg <= buttons;
		end else begin
			shreg <= shreg >> 1;
		end
	end

	// Released line reads high, a pressed button pulls it low
	assign data = ~shreg[0];

endmodule

/* testbench/tb_periph_top.sv */
// Testbench for the peripheral subsystem with directed bus tests and two pad models
module tb_periph_top
	import axil_pkg::*;
	import soc_map_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned WAIT_LIMIT       = 20;
	localparam int unsigned PAD_FRAME_CYCLES = PAD_TICK_CYCLES * (2 * PAD_BITS + 2);

	logic         clk_50mhz;
	logic         resetn;
	logic         awvalid;
	logic         awready;
	axil_addr_t   aw_addr;
	logic         wvalid;
	logic         wready;
	axil_w_t      w;
	logic         bvalid;
	logic         bready;
	axil_resp_t   bresp;
	logic         arvalid;
	logic         arready;
	axil_addr_t   ar_addr;
	logic         rvalid;
	logic         rready;
	axil_r_t      r;
	logic         pad0_data;
	logic         pad1_data;
	logic         pad_latch;
	logic         pad_clock;
	pad_buttons_t pad0_buttons;
	pad_buttons_t pad1_buttons;
	int unsigned  errors;
	int unsigned  timeouts;
	int unsigned  cycle_count = 0;
	axil_data_t   mem_model [MEM_WORDS];

	periph_top i_dut (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.awvalid(awvalid),
		.awready(awready),
		.aw_addr(aw_addr),
		.wvalid(wvalid),
		.wready(wready),
		.w(w),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.ar_addr(ar_addr),
		.rvalid(rvalid),
		.rready(rready),
		.r(r),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data),
		.pad_latch(pad_latch),
		.pad_clock(pad_clock)
	);

	tb_pad_model i_pad0 (
		.pad_latch(pad_latch),
		.pad_clock(pad_clock),
		.buttons(pad0_buttons),
		.data(pad0_data)
	);

	tb_pad_model i_pad1 (
		.pad_latch(pad_latch),
		.pad_clock(pad_clock),
		.buttons(pad1_buttons),
		.data(pad1_data)
	);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	always @(posedge clk_50mhz) begin
		cycle_count <= cycle_count + 1;
	end

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timed out waiting for %s", what);
	endtask

	task automatic idle_cycles(input int unsigned n);
		repeat (n) @(posedge clk_50mhz);
		#2;
	endtask

	// Old word with the strobed bytes replaced
	function automatic axil_data_t merge_bytes(input axil_data_t old_word,
			input axil_data_t new_word, input axil_strb_t strb);
		axil_data_t mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
			input axil_strb_t strb, output axil_resp_t resp);
		int unsigned n;
		awvalid = 1'b1;
		aw_addr = addr;
		wvalid  = 1'b1;
		w       = '{data: data, strb: strb};
		n = 0;
		@(negedge clk_50mhz);
		while (!(awready && wready) && n < WAIT_LIMIT) begin
			@(negedge clk_50mhz);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			report_timeout("the write address and data handshake");
		end
		@(posedge clk_50mhz);
		#2;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		@(negedge clk_50mhz);
		while (!bvalid && n < WAIT_LIMIT) begin
			@(negedge clk_50mhz);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			report_timeout("the write response");
		end
		resp = bresp;
		@(posedge clk_50mhz);
		#2;
	endtask

	// Holds arvalid until the handshake edge, then drops it
	task automatic wait_arready();
		int unsigned n;
		n = 0;
		@(negedge clk_50mhz);
		while (!arready && n < WAIT_LIMIT) begin
			@(negedge clk_50mhz);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			report_timeout("the read address handshake");
		end
		@(posedge clk_50mhz);
		#2;
		arvalid = 1'b0;
	endtask

	task automatic wait_rvalid();
		int unsigned n;
		n = 0;
		@(negedge clk_50mhz);
		while (!rvalid && n < WAIT_LIMIT) begin
			@(negedge clk_50mhz);
			n++;
		end
		if (n >= WAIT_LIMIT) begin
			report_timeout("the read data");
		end
	endtask

	task automatic finish_read(output axil_data_t data, output axil_resp_t resp);
		wait_rvalid();
		data = r.data;
		resp = r.resp;
		@(posedge clk_50mhz);
		#2;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp);
		arvalid = 1'b1;
		ar_addr = addr;
		wait_arready();
		finish_read(data, resp);
	endtask

	task automatic test_memory_round_trip();
		word_index_t idx [8];
		axil_data_t  data;
		axil_resp_t  resp;
		for (int i = 0; i < 8; i++) begin
			idx[i] = word_index_t'($urandom);
			mem_model[idx[i]] = $urandom;
			axil_write(MEM_BASE + {22'b0, idx[i], 2'b00}, mem_model[idx[i]], 4'hf, resp);
			check_word("bresp", RESP_OKAY, resp);
		end
		for (int i = 0; i < 8; i++) begin
			axil_read(MEM_BASE + {22'b0, idx[i], 2'b00}, data, resp);
			check_word("rresp", RESP_OKAY, resp);
			check_word("rdata", mem_model[idx[i]], data);
		end
	endtask

	task automatic test_byte_strobes();
		axil_strb_t patterns [2];
		axil_data_t first;
		axil_data_t second;
		axil_data_t data;
		axil_resp_t resp;
		patterns[0] = 4'b0101;
		patterns[1] = 4'b1000;
		for (int i = 0; i < 2; i++) begin
			first  = $urandom;
			second = $urandom;
			axil_write(MEM_BASE + 32'h40, first, 4'hf, resp);
			axil_write(MEM_BASE + 32'h40, second, patterns[i], resp);
			check_word("bresp", RESP_OKAY, resp);
			axil_read(MEM_BASE + 32'h40, data, resp);
			check_word("rresp", RESP_OKAY, resp);
			check_word("rdata", merge_bytes(first, second, patterns[i]), data);
		end
	endtask

	task automatic test_counter();
		axil_data_t first;
		axil_data_t second;
		axil_resp_t resp;
		axil_read(COUNTER_BASE, first, resp);
		check_word("rresp", RESP_OKAY, resp);
		idle_cycles(100);
		axil_read(COUNTER_BASE, second, resp);
		check_word("rresp", RESP_OKAY, resp);
		if (second - first < 100) begin
			errors++;
			$display("error counter_delta expected >= %h actual %h", 32'd100, second - first);
		end
		axil_write(COUNTER_BASE, $urandom, 4'hf, resp);
		check_word("bresp", RESP_SLVERR, resp);
	endtask

	task automatic test_pads();
		axil_data_t  expected;
		axil_data_t  data;
		axil_resp_t  resp;
		int unsigned start;
		for (int round = 0; round < 2; round++) begin
			pad0_buttons = pad_buttons_t'($urandom);
			pad1_buttons = pad_buttons_t'($urandom);
			expected     = {16'h0, pad1_buttons, pad0_buttons};
			start        = cycle_count;
			do begin
				axil_read(PAD_BASE, data, resp);
			end while (data !== expected && cycle_count - start < 3 * PAD_FRAME_CYCLES);
			if (data !== expected) begin
				report_timeout("the pad buttons to reach the result register");
			end
			check_word("rresp", RESP_OKAY, resp);
		end
		axil_write(PAD_BASE, $urandom, 4'hf, resp);
		check_word("bresp", RESP_SLVERR, resp);
	endtask

	task automatic test_unmapped();
		axil_data_t data;
		axil_resp_t resp;
		axil_read(32'h0300_0000, data, resp);
		check_word("rresp", RESP_DECERR, resp);
		check_word("rdata", 32'h0, data);
		axil_write(32'h0300_0000, $urandom, 4'hf, resp);
		check_word("bresp", RESP_DECERR, resp);
	endtask

	task automatic test_back_pressure();
		axil_data_t word_a;
		axil_data_t word_b;
		axil_data_t data;
		axil_resp_t resp;
		axil_r_t    held;
		word_a = $urandom;
		word_b = $urandom;
		axil_write(MEM_BASE + 32'h80, word_a, 4'hf, resp);
		axil_write(MEM_BASE + 32'h84, word_b, 4'hf, resp);
		rready  = 1'b0;
		arvalid = 1'b1;
		ar_addr = MEM_BASE + 32'h80;
		wait_arready();
		wait_rvalid();
		held = r;
		@(posedge clk_50mhz);
		#2;
		// Next read offered while the response is stalled
		arvalid = 1'b1;
		ar_addr = MEM_BASE + 32'h84;
		repeat (10) begin
			@(negedge clk_50mhz);
			check_word("rvalid", 32'd1, {31'b0, rvalid});
			check_word("rdata", held.data, r.data);
			check_word("arready", 32'd0, {31'b0, arready});
		end
		@(posedge clk_50mhz);
		#2;
		rready = 1'b1;
		finish_read(data, resp);
		check_word("rresp", RESP_OKAY, resp);
		check_word("rdata", word_a, data);
		wait_arready();
		finish_read(data, resp);
		check_word("rresp", RESP_OKAY, resp);
		check_word("rdata", word_b, data);
	endtask

	initial begin
		void'($urandom(76703));
		resetn       = 1'b0;
		awvalid      = 1'b0;
		aw_addr      = '0;
		wvalid       = 1'b0;
		w            = '0;
		bready       = 1'b1;
		arvalid      = 1'b0;
		ar_addr      = '0;
		rready       = 1'b1;
		pad0_buttons = '0;
		pad1_buttons = '0;
		errors       = 0;
		timeouts     = 0;
		repeat (5) @(posedge clk_50mhz);
		#2;
		resetn = 1'b1;
		idle_cycles(2);

		test_memory_round_trip();
		test_byte_strobes();
		test_counter();
		test_pads();
		test_unmapped();
		test_back_pressure();

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* files.f */
design/axil_pkg.sv
design/soc_map_pkg.sv
design/axil_decoder.sv
design/scratch_memory.sv
design/cycle_counter.sv
design/pad_reader.sv
design/periph_top.sv
testbench/tb_pad_model.sv
testbench/tb_periph_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_top -f files.f

out=$(./obj_dir/Vtb_periph_top)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Regression passed'
